//--- project.f
+incdir+tb
source/brch_pkg.sv
source/brch_detect.sv
source/brch_ckpt_store.sv
source/brch_flush_match.sv
source/brch_ctrl.sv
source/brch_unit_top.sv
tb/brch_unit_tb.sv

//--- Makefile
# Verilator build for the branch checkpoint unit testbench

VERILATOR ?= verilator
TOP       ?= brch_unit_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
SIM_ARGS  ?=

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard source/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# exit status of the simulator is the pass or fail result
run: compile
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/brch_unit_tb_vectors.svh
localparam int NUM_ROWS = 22;

// column order is cls (2 bits per slot, slot 0 low), need, nxt_indx, curr_pos,
// mis_pred, brch_mis_indx, cmt_brch, cmt_brch_indx,
// then expected flush, all_nop, flush_pos, brch_stall
localparam vec_t VECS [NUM_ROWS] = '{
   // row 0 idle right after reset
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 1'b0, 7'h00, 1'b0},
   // row 1 has a branch in slot 2 and an invalid slot 3 with class set
   '{8'hD0, 4'h7, 6'h08, 7'h20, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 1'b0, 7'h00, 1'b0},
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 1'b0, 7'h00, 1'b1},
   // row 3 mispredicts tag 0x0a at pos 0x22
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b1, 6'h0A, 1'b0, 6'h00, 1'b1, 1'b1, 7'h22, 1'b1},
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 1'b0, 7'h00, 1'b0},
   // row 5 has two branches in slots 0 and 3
   '{8'h42, 4'hF, 6'h10, 7'h30, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 1'b0, 7'h00, 1'b0},
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 1'b0, 7'h00, 1'b1},
   // rows 7 and 8 commit both in order
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b0, 6'h00, 1'b1, 6'h10, 1'b0, 1'b0, 7'h00, 1'b1},
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b0, 6'h00, 1'b1, 6'h13, 1'b0, 1'b0, 7'h00, 1'b1},
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 1'b0, 7'h00, 1'b0},
   // row 10 has slots 0 1 3 valid and branches in 1 and 3 with slot 2 masked
   '{8'h9C, 4'hB, 6'h20, 7'h40, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 1'b0, 7'h00, 1'b0},
   // row 11 mispredicts the younger one while a full store sees a group
   '{8'h01, 4'h1, 6'h30, 7'h50, 1'b1, 6'h23, 1'b0, 6'h00, 1'b1, 1'b1, 7'h42, 1'b1},
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 1'b0, 7'h00, 1'b1},
   // row 13 mispredicts the older one with room free so its group is dropped
   '{8'h01, 4'h1, 6'h30, 7'h50, 1'b1, 6'h21, 1'b0, 6'h00, 1'b1, 1'b1, 7'h41, 1'b1},
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 1'b0, 7'h00, 1'b0},
   // row 15 has branches in slots 2 and 3 where slot 2 is the first valid one
   '{8'h53, 4'hC, 6'h30, 7'h50, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 1'b0, 7'h00, 1'b0},
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 1'b0, 7'h00, 1'b1},
   // row 17 hits the older one and empties the store
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b1, 6'h32, 1'b0, 6'h00, 1'b1, 1'b1, 7'h50, 1'b1},
   '{8'h02, 4'h1, 6'h38, 7'h60, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 1'b0, 7'h00, 1'b0},
   // row 19 commits a tag that is not at head
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b0, 6'h00, 1'b1, 6'h39, 1'b0, 1'b0, 7'h00, 1'b1},
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b1, 6'h38, 1'b0, 6'h00, 1'b1, 1'b1, 7'h60, 1'b1},
   '{8'h00, 4'h0, 6'h00, 7'h00, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 1'b0, 7'h00, 1'b0}
};

//--- tb/brch_unit_tb.sv
module brch_unit_tb import brch_pkg::*;
();

   localparam int PERIOD     = 40;
   localparam int RST_CYCLES = 16;

   // one table row, stimulus then expected outputs
   typedef struct packed
   {
      logic [7:0] cls;        // class bits 31:30 per slot, slot 0 low
      logic [3:0] need;       // pr_need_inst
      brch_tag_t  nxt;
      rob_pos_t   pos;
      logic       mis;
      brch_tag_t  mis_tag;
      logic       cmt;
      brch_tag_t  cmt_tag;
      logic       exp_flush;
      logic       exp_nop;
      rob_pos_t   exp_fpos;
      logic       exp_stall;
   } vec_t;

`include "brch_unit_tb_vectors.svh"

   localparam int TIMEOUT = (NUM_ROWS + RST_CYCLES + 10) * PERIOD;

   logic      clk;
   logic      rst_n;
   inst_t     inst0, inst1, inst2, inst3;
   logic [3:0] pr_need_inst;
   brch_tag_t nxt_indx;
   rob_pos_t  curr_pos;
   logic      mis_pred;
   brch_tag_t brch_mis_indx;
   logic      cmt_brch;
   brch_tag_t cmt_brch_indx;
   logic      flush;
   rob_pos_t  flush_pos;
   logic      all_nop;
   logic      brch_stall;
   int        row_idx;    // row under test, for error lines

   brch_unit_top brch_unit_top_i
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .inst0         (inst0),
      .inst1         (inst1),
      .inst2         (inst2),
      .inst3         (inst3),
      .pr_need_inst  (pr_need_inst),
      .nxt_indx      (nxt_indx),
      .curr_pos      (curr_pos),
      .mis_pred      (mis_pred),
      .brch_mis_indx (brch_mis_indx),
      .cmt_brch      (cmt_brch),
      .cmt_brch_indx (cmt_brch_indx),
      .flush         (flush),
      .flush_pos     (flush_pos),
      .all_nop       (all_nop),
      .brch_stall    (brch_stall)
   );

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // random filler, class bits forced from the table
   function automatic inst_t make_inst(input logic [1:0] cls);
      logic [95:0] r;
      inst_t       w;
      r = {$urandom, $urandom, $urandom};
      w = r[65:0];
      w[31:30] = cls;
      return w;
   endfunction

   task automatic drive_row(input vec_t v);
      inst0         = make_inst(v.cls[1:0]);
      inst1         = make_inst(v.cls[3:2]);
      inst2         = make_inst(v.cls[5:4]);
      inst3         = make_inst(v.cls[7:6]);
      pr_need_inst  = v.need;
      nxt_indx      = v.nxt;
      curr_pos      = v.pos;
      mis_pred      = v.mis;
      brch_mis_indx = v.mis_tag;
      cmt_brch      = v.cmt;
      cmt_brch_indx = v.cmt_tag;
   endtask

   task automatic check_bit(input string name, input logic exp_v, input logic act_v);
      if (act_v !== exp_v)
      begin
         $display("FAIL %s row %0d expected %h got %h", name, row_idx, exp_v, act_v);
         $display("sim failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic check_pos(input string name, input rob_pos_t exp_v, input rob_pos_t act_v);
      if (act_v !== exp_v)
      begin
         $display("FAIL %s row %0d expected %h got %h", name, row_idx, exp_v, act_v);
         $display("sim failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   // watchdog sized from table length plus reset
   initial
   begin
      #(TIMEOUT);
      $display("timeout: vector loop did not finish within %0d time units", TIMEOUT);
      $display("sim failed");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      void'($urandom(75));   // one seed for the whole run
      row_idx       = -1;
      rst_n         = 1'b0;
      inst0         = '0;
      inst1         = '0;
      inst2         = '0;
      inst3         = '0;
      pr_need_inst  = '0;
      nxt_indx      = '0;
      curr_pos      = '0;
      mis_pred      = 1'b0;
      brch_mis_indx = '0;
      cmt_brch      = 1'b0;
      cmt_brch_indx = '0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         @(negedge clk);
         row_idx = i;
         drive_row(VECS[i]);
         #(PERIOD / 4);   // settled, well before next rising edge
         check_bit("flush", VECS[i].exp_flush, flush);
         check_bit("all_nop", VECS[i].exp_nop, all_nop);
         check_pos("flush_pos", VECS[i].exp_fpos, flush_pos);
         check_bit("brch_stall", VECS[i].exp_stall, brch_stall);
      end
      $display("sim passed");
      $finish;
   end

endmodule

//--- source/brch_unit_top.sv
module brch_unit_top import brch_pkg::*;
#(
   parameter int BRCH_DEPTH = 2
)
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  inst_t                  inst0,
   input  inst_t                  inst1,
   input  inst_t                  inst2,
   input  inst_t                  inst3,
   input  logic [DISP_WIDTH-1:0]  pr_need_inst,
   input  brch_tag_t              nxt_indx,
   input  rob_pos_t               curr_pos,
   input  logic                   mis_pred,
   input  brch_tag_t              brch_mis_indx,
   input  logic                   cmt_brch,
   input  brch_tag_t              cmt_brch_indx,
   output logic                   flush,
   output rob_pos_t               flush_pos,
   output logic                   all_nop,
   output logic                   brch_stall
);

   localparam int PTR_W = $clog2(BRCH_DEPTH);

   disp_grp_t              grp;
   brch_cand_t             cand;
   logic [PTR_W-1:0]       wr_ptr;
   logic [1:0]             wr_cnt;
   logic [PTR_W-1:0]       head;
   logic [BRCH_DEPTH-1:0]  entry_valid;
   ckpt_t [BRCH_DEPTH-1:0] entries;
   logic                   cmt_hit;
   logic                   mis_hit;
   logic [PTR_W-1:0]       mis_idx;

   // slot 0 goes in the low word
   assign grp.inst     = {inst3, inst2, inst1, inst0};
   assign grp.valid    = pr_need_inst;
   assign grp.base_tag = nxt_indx;
   assign grp.base_pos = curr_pos;

   brch_detect brch_detect_i
   (
      .grp  (grp),
      .cand (cand)
   );

   brch_ctrl #(.BRCH_DEPTH(BRCH_DEPTH)) brch_ctrl_i
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .cand_cnt    (cand.cnt),
      .mis_pred    (mis_pred),
      .mis_hit     (mis_hit),
      .mis_idx     (mis_idx),
      .cmt_hit     (cmt_hit),
      .wr_ptr      (wr_ptr),
      .wr_cnt      (wr_cnt),
      .head        (head),
      .entry_valid (entry_valid),
      .flush       (flush),
      .all_nop     (all_nop),
      .brch_stall  (brch_stall)
   );

   brch_ckpt_store #(.BRCH_DEPTH(BRCH_DEPTH)) brch_ckpt_store_i
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .cand    (cand),
      .wr_ptr  (wr_ptr),
      .wr_cnt  (wr_cnt),
      .entries (entries)
   );

   brch_flush_match #(.BRCH_DEPTH(BRCH_DEPTH)) brch_flush_match_i
   (
      .entries       (entries),
      .entry_valid   (entry_valid),
      .head          (head),
      .mis_pred      (mis_pred),
      .brch_mis_indx (brch_mis_indx),
      .cmt_brch      (cmt_brch),
      .cmt_brch_indx (cmt_brch_indx),
      .flush_pos     (flush_pos),
      .mis_hit       (mis_hit),
      .mis_idx       (mis_idx),
      .cmt_hit       (cmt_hit)
   );

endmodule

//--- source/brch_ctrl.sv
module brch_ctrl import brch_pkg::*;
#(
   parameter int BRCH_DEPTH = 2
)
(
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [1:0]                      cand_cnt,
   input  logic                            mis_pred,
   input  logic                            mis_hit,
   input  logic [$clog2(BRCH_DEPTH)-1:0]   mis_idx,
   input  logic                            cmt_hit,
   output logic [$clog2(BRCH_DEPTH)-1:0]   wr_ptr,
   output logic [1:0]                      wr_cnt,
   output logic [$clog2(BRCH_DEPTH)-1:0]   head,
   output logic [BRCH_DEPTH-1:0]           entry_valid,
   output logic                            flush,
   output logic                            all_nop,
   output logic                            brch_stall
);

   localparam int PTR_W = $clog2(BRCH_DEPTH);
   localparam int CNT_W = $clog2(BRCH_DEPTH + 1);   // occupancy reaches BRCH_DEPTH

   logic [PTR_W-1:0] tail;      // next free slot
   logic [CNT_W-1:0] occ;       // live entries
   logic [CNT_W-1:0] free_cnt;
   logic [PTR_W-1:0] trunc_len; // entries older than the mispredicted one
   logic [PTR_W-1:0] offs;      // distance of an entry from head

   assign free_cnt = CNT_W'(BRCH_DEPTH) - occ;

   // grant what fits; mispredict kills the whole group
   always_comb
   begin
      if (mis_pred)
         wr_cnt = 2'd0;
      else if (CNT_W'(cand_cnt) > free_cnt)
         wr_cnt = 2'(free_cnt);   // extra branches dropped
      else
         wr_cnt = cand_cnt;
   end

   assign wr_ptr    = tail;
   assign trunc_len = mis_idx - head;   // wraps mod depth

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         head <= '0;
         tail <= '0;
         occ  <= '0;
      end
      else if (mis_pred)
      begin
         if (mis_hit)
         begin
            tail <= mis_idx;              // drop matching entry and younger
            occ  <= CNT_W'(trunc_len);
         end
      end
      else
      begin
         tail <= tail + PTR_W'(wr_cnt);
         head <= head + PTR_W'(cmt_hit);  // pop oldest on commit
         occ  <= occ + CNT_W'(wr_cnt) - CNT_W'(cmt_hit);
      end
   end

   // entry i is live when it sits within occ slots of head
   always_comb
   begin
      offs = '0;
      for (int i = 0; i < BRCH_DEPTH; i++)
      begin
         offs           = PTR_W'(i) - head;
         entry_valid[i] = CNT_W'(offs) < occ;
      end
   end

   // front end should hold when a full group might not fit
   assign brch_stall = free_cnt < CNT_W'(MAX_BRCH_GRP);

   assign flush   = mis_pred;   // same cycle, no register
   assign all_nop = mis_pred;

endmodule

//--- source/brch_flush_match.sv
module brch_flush_match import brch_pkg::*;
#(
   parameter int BRCH_DEPTH = 2
)
(
   input  ckpt_t [BRCH_DEPTH-1:0]          entries,
   input  logic  [BRCH_DEPTH-1:0]          entry_valid,
   input  logic  [$clog2(BRCH_DEPTH)-1:0]  head,
   input  logic                            mis_pred,
   input  brch_tag_t                       brch_mis_indx,
   input  logic                            cmt_brch,
   input  brch_tag_t                       cmt_brch_indx,
   output rob_pos_t                        flush_pos,
   output logic                            mis_hit,
   output logic  [$clog2(BRCH_DEPTH)-1:0]  mis_idx,
   output logic                            cmt_hit
);

   localparam int PTR_W = $clog2(BRCH_DEPTH);

   logic [PTR_W-1:0] idx;   // entry under test

   // scan youngest to oldest so the oldest hit is the one that sticks
   always_comb
   begin
      mis_hit   = 1'b0;
      mis_idx   = '0;
      flush_pos = '0;   // stays zero with no mispredict
      idx       = '0;
      for (int i = BRCH_DEPTH - 1; i >= 0; i--)
      begin
         idx = head + PTR_W'(i);
         if (mis_pred && entry_valid[idx] && (entries[idx].tag == brch_mis_indx))
         begin
            mis_hit   = 1'b1;
            mis_idx   = idx;
            flush_pos = entries[idx].pos;
         end
      end
   end

   // commits retire in order, so only the head can match
   assign cmt_hit = cmt_brch && entry_valid[head] && (entries[head].tag == cmt_brch_indx);

endmodule

//--- source/brch_ckpt_store.sv
module brch_ckpt_store import brch_pkg::*;
#(
   parameter int BRCH_DEPTH = 2
)
(
   input  logic                            clk,
   input  logic                            rst_n,
   input  brch_cand_t                      cand,
   input  logic [$clog2(BRCH_DEPTH)-1:0]   wr_ptr,
   input  logic [1:0]                      wr_cnt,
   output ckpt_t [BRCH_DEPTH-1:0]          entries
);

   localparam int PTR_W = $clog2(BRCH_DEPTH);

   logic [PTR_W-1:0] wr_ptr_p1;   // second lane slot

   assign wr_ptr_p1 = wr_ptr + 1'b1;   // wraps, depth is a power of two

   // circular array, lane 0 at tail, lane 1 right after it
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         entries <= '0;
      end
      else
      begin
         for (int i = 0; i < BRCH_DEPTH; i++)
         begin
            if ((wr_cnt != 2'd0) && (wr_ptr == PTR_W'(i)))
               entries[i] <= cand.ck0;
            else if ((wr_cnt == 2'd2) && (wr_ptr_p1 == PTR_W'(i)))
               entries[i] <= cand.ck1;   // only when both lanes granted
         end
      end
   end

endmodule

//--- source/brch_detect.sv
module brch_detect import brch_pkg::*;
(
   input  disp_grp_t  grp,
   output brch_cand_t cand
);

   localparam int VCNT_W = $clog2(DISP_WIDTH + 1);   // wide enough for all slots valid

   logic [DISP_WIDTH-1:0] is_brch;   // per slot branch flag
   logic [VCNT_W-1:0]     vcnt;      // valid slots seen so far
   logic [1:0]            found;     // branches picked so far
   ckpt_t                 slot_ck;   // checkpoint of current slot

   // branch class lives in bits 31:30, anything nonzero is a branch
   always_comb
   begin
      for (int k = 0; k < DISP_WIDTH; k++)
      begin
         is_brch[k] = grp.valid[k] && (grp.inst[k][31:30] != 2'b00);
      end
   end

   // walk slots in order, picking first two branches
   always_comb
   begin
      cand    = '0;
      vcnt    = '0;
      found   = 2'd0;
      slot_ck = '0;
      for (int k = 0; k < DISP_WIDTH; k++)
      begin
         slot_ck.tag = grp.base_tag + brch_tag_t'(k);   // tag per slot, not per branch
         slot_ck.pos = grp.base_pos + rob_pos_t'(vcnt); // prefix count of valid slots
         if (is_brch[k])
         begin
            if (found == 2'd0)
               cand.ck0 = slot_ck;
            else if (found == 2'd1)
               cand.ck1 = slot_ck;
            // third and later branches are not recorded
            if (found < 2'(MAX_BRCH_GRP))
               found = found + 2'd1;   // saturates at 2
         end
         vcnt = vcnt + VCNT_W'(grp.valid[k]);
      end
      cand.cnt = found;
   end

endmodule

//--- source/brch_pkg.sv
package brch_pkg;

   // dispatch group shape
   localparam int DISP_WIDTH   = 4;   // slots per group
   localparam int MAX_BRCH_GRP = 2;   // branches kept per group

   typedef logic [65:0] inst_t;       // raw dispatched word
   typedef logic [5:0]  brch_tag_t;   // branch tag
   typedef logic [6:0]  rob_pos_t;    // reorder pointer

   // one checkpoint entry, tag in the upper bits
   typedef struct packed
   {
      brch_tag_t tag;
      rob_pos_t  pos;
   } ckpt_t;

   // everything that arrives with a group
   typedef struct packed
   {
      inst_t [DISP_WIDTH-1:0]  inst;      // slot 0 in the low word
      logic  [DISP_WIDTH-1:0]  valid;     // pr_need_inst
      brch_tag_t               base_tag;  // tag of slot 0
      rob_pos_t                base_pos;  // rob pos of first valid slot
   } disp_grp_t;

   // up to two branches picked out of a group
   typedef struct packed
   {
      ckpt_t      ck0;   // oldest branch
      ckpt_t      ck1;   // second one
      logic [1:0] cnt;   // 0..2
   } brch_cand_t;

endpackage
